// File: hdl/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// buffer geometry
`define ROB_DEPTH 16     // entry count as a power of two
`define COMMIT_WIDTH 2   // retire lanes per cycle

// fetch targets
`define RESET_PC 32'h0000_1000     // idle redirect target
`define TRAP_VECTOR 32'h0000_0100  // exception handler entry

`endif

// File: hdl/rob_pkg.sv
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    // slot index doubles as operation id
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // one extra bit so a full buffer is representable
    typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

    // written at dispatch
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pnpc;   // predicted next pc
        logic [4:0]  rd;
    } rob_dec_t;

    // written at write-back
    typedef struct packed {
        logic [31:0] npc;    // actual next pc
        logic        exc;
        logic [5:0]  cause;
    } rob_exe_t;

endpackage

`default_nettype wire

// File: hdl/rob_ram.sv
`timescale 1ns/1ps
`default_nettype none

module rob_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16,
    parameter int  RPORTS  = 2
) (
    input  wire logic                                  clk,
    input  wire logic                                  we,
    input  wire logic [$clog2(DEPTH)-1:0]              waddr,
    input  wire entry_t                                wdata,
    input  wire logic [RPORTS-1:0][$clog2(DEPTH)-1:0]  raddr,
    output      entry_t [RPORTS-1:0]                   rdata
);

    entry_t mem [DEPTH];   // one payload per slot

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read ports see the array before this edge's write
    always_comb begin
        for (int i = 0; i < RPORTS; i++) begin
            rdata[i] = mem[raddr[i]];
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_alloc import rob_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        disp_valid,
    output      logic        disp_ready,
    input  wire logic [31:0] disp_pc,
    input  wire logic [31:0] disp_pnpc,
    input  wire logic [4:0]  disp_rd,
    output      rob_idx_t    disp_opid,
    input  wire rob_cnt_t    retire_cnt,
    input  wire logic        flush,
    input  wire logic        redirect,
    output      rob_cnt_t    count,
    output      logic        alloc_fire,
    output      logic        dec_we,
    output      rob_idx_t    dec_waddr,
    output      rob_dec_t    dec_wdata
);

    rob_idx_t tail;
    logic     full;

    assign full       = (count == rob_cnt_t'(`ROB_DEPTH));
    assign disp_ready = !full && !redirect;   // no new entries while redirecting
    assign alloc_fire = disp_valid && disp_ready;
    assign disp_opid  = tail;

    // decode half of the entry goes in at the tail
    assign dec_we          = alloc_fire;
    assign dec_waddr       = tail;
    assign dec_wdata.pc    = disp_pc;
    assign dec_wdata.pnpc  = disp_pnpc;
    assign dec_wdata.rd    = disp_rd;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else if (alloc_fire) begin
            tail <= tail + 1'b1;   // wraps at ROB_DEPTH
        end
    end

    // in and out can both happen on one edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            count <= count + rob_cnt_t'(alloc_fire) - retire_cnt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_writeback import rob_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  exe_valid,
    input  wire rob_idx_t              exe_opid,
    input  wire logic [31:0]           exe_npc,
    input  wire logic                  exe_exc,
    input  wire logic [5:0]            exe_cause,
    input  wire logic                  alloc_fire,
    input  wire rob_idx_t              alloc_idx,
    input  wire logic                  flush,
    output      logic                  exe_we,
    output      rob_idx_t              exe_waddr,
    output      rob_exe_t              exe_wdata,
    output      logic [`ROB_DEPTH-1:0] done
);

    // result lands in the execute half of its entry
    assign exe_we          = exe_valid;
    assign exe_waddr       = exe_opid;
    assign exe_wdata.npc   = exe_npc;
    assign exe_wdata.exc   = exe_exc;
    assign exe_wdata.cause = exe_cause;

    // done is registered, so commit sees a result one cycle after it is written
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            done <= '0;
        end else begin
            if (alloc_fire) begin
                done[alloc_idx] <= 1'b0;   // stale bit from the slot's last use
            end
            if (exe_valid) begin
                done[exe_opid] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_commit import rob_pkg::*; (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire rob_cnt_t                             count,
    input  wire logic [`ROB_DEPTH-1:0]                done,
    output      rob_idx_t [`COMMIT_WIDTH-1:0]         raddr,
    input  wire rob_dec_t [`COMMIT_WIDTH-1:0]         dec_rdata,
    input  wire rob_exe_t [`COMMIT_WIDTH-1:0]         exe_rdata,
    output      logic [`COMMIT_WIDTH-1:0]             com_valid,
    output      rob_idx_t [`COMMIT_WIDTH-1:0]         com_opid,
    output      logic [`COMMIT_WIDTH-1:0][31:0]       com_pc,
    output      logic [`COMMIT_WIDTH-1:0][4:0]        com_rd,
    output      rob_cnt_t                             retire_cnt,
    output      logic                                 redirect,
    output      logic [31:0]                          redirect_pc,
    output      logic                                 exception,
    output      logic [31:0]                          epc,
    output      logic [5:0]                           cause,
    output      logic                                 flush
);

    rob_idx_t                 head;
    logic [`COMMIT_WIDTH-1:0] lane_ok;   // live and finished

    // lanes look at consecutive slots from the head
    always_comb begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            raddr[i]    = head + rob_idx_t'(i);
            lane_ok[i]  = (rob_cnt_t'(i) < count) && done[raddr[i]];
            com_opid[i] = raddr[i];
            com_pc[i]   = dec_rdata[i].pc;
            com_rd[i]   = dec_rdata[i].rd;
        end
    end

    // Walk the lanes in order. The first lane that is not ready, or that
    // redirects, ends the group; an excepting lane itself does not retire.
    always_comb begin
        logic stop;
        stop        = 1'b0;
        com_valid   = '0;
        redirect    = 1'b0;
        redirect_pc = `RESET_PC;   // idle value
        exception   = 1'b0;
        epc         = '0;
        cause       = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (!stop && lane_ok[i]) begin
                if (exe_rdata[i].exc) begin
                    exception   = 1'b1;
                    epc         = dec_rdata[i].pc;
                    cause       = exe_rdata[i].cause;
                    redirect    = 1'b1;
                    redirect_pc = `TRAP_VECTOR;
                    stop        = 1'b1;
                end else begin
                    com_valid[i] = 1'b1;
                    if (exe_rdata[i].npc != dec_rdata[i].pnpc) begin
                        redirect    = 1'b1;            // mispredicted entry still retires
                        redirect_pc = exe_rdata[i].npc;
                        stop        = 1'b1;
                    end
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_comb begin
        retire_cnt = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            retire_cnt = retire_cnt + rob_cnt_t'(com_valid[i]);
        end
    end

    // whole buffer empties at the edge closing the redirect cycle
    assign flush = redirect;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
        end else begin
            head <= head + rob_idx_t'(retire_cnt);
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_top import rob_pkg::*; (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            disp_valid,
    output      logic                            disp_ready,
    input  wire logic [31:0]                     disp_pc,
    input  wire logic [31:0]                     disp_pnpc,
    input  wire logic [4:0]                      disp_rd,
    output      rob_idx_t                        disp_opid,
    input  wire logic                            exe_valid,
    input  wire rob_idx_t                        exe_opid,
    input  wire logic [31:0]                     exe_npc,
    input  wire logic                            exe_exc,
    input  wire logic [5:0]                      exe_cause,
    output      logic [`COMMIT_WIDTH-1:0]        com_valid,
    output      rob_idx_t [`COMMIT_WIDTH-1:0]    com_opid,
    output      logic [`COMMIT_WIDTH-1:0][31:0]  com_pc,
    output      logic [`COMMIT_WIDTH-1:0][4:0]   com_rd,
    output      logic                            redirect,
    output      logic [31:0]                     redirect_pc,
    output      logic                            exception,
    output      logic [31:0]                     epc,
    output      logic [5:0]                      cause
);

    rob_cnt_t                     count;
    rob_cnt_t                     retire_cnt;
    logic                         flush;
    logic                         alloc_fire;
    logic                         dec_we;
    rob_idx_t                     dec_waddr;
    rob_dec_t                     dec_wdata;
    logic                         exe_we;
    rob_idx_t                     exe_waddr;
    rob_exe_t                     exe_wdata;
    logic [`ROB_DEPTH-1:0]        done;
    rob_idx_t [`COMMIT_WIDTH-1:0] raddr;       // shared by both RAMs
    rob_dec_t [`COMMIT_WIDTH-1:0] dec_rdata;
    rob_exe_t [`COMMIT_WIDTH-1:0] exe_rdata;

    rob_alloc rob_alloc_inst (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_ready(disp_ready),
        .disp_pc(disp_pc), .disp_pnpc(disp_pnpc), .disp_rd(disp_rd),
        .disp_opid(disp_opid), .retire_cnt(retire_cnt),
        .flush(flush), .redirect(redirect), .count(count),
        .alloc_fire(alloc_fire),
        .dec_we(dec_we), .dec_waddr(dec_waddr), .dec_wdata(dec_wdata)
    );

    rob_writeback rob_writeback_inst (
        .clk(clk), .rst(rst),
        .exe_valid(exe_valid), .exe_opid(exe_opid), .exe_npc(exe_npc),
        .exe_exc(exe_exc), .exe_cause(exe_cause),
        .alloc_fire(alloc_fire), .alloc_idx(dec_waddr), .flush(flush),
        .exe_we(exe_we), .exe_waddr(exe_waddr), .exe_wdata(exe_wdata),
        .done(done)
    );

    rob_commit rob_commit_inst (
        .clk(clk), .rst(rst),
        .count(count), .done(done), .raddr(raddr),
        .dec_rdata(dec_rdata), .exe_rdata(exe_rdata),
        .com_valid(com_valid), .com_opid(com_opid), .com_pc(com_pc), .com_rd(com_rd),
        .retire_cnt(retire_cnt),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .exception(exception), .epc(epc), .cause(cause),
        .flush(flush)
    );

    rob_ram #(.entry_t(rob_dec_t), .DEPTH(`ROB_DEPTH), .RPORTS(`COMMIT_WIDTH)) dec_ram_inst (
        .clk(clk), .we(dec_we), .waddr(dec_waddr), .wdata(dec_wdata),
        .raddr(raddr), .rdata(dec_rdata)
    );

    rob_ram #(.entry_t(rob_exe_t), .DEPTH(`ROB_DEPTH), .RPORTS(`COMMIT_WIDTH)) exe_ram_inst (
        .clk(clk), .we(exe_we), .waddr(exe_waddr), .wdata(exe_wdata),
        .raddr(raddr), .rdata(exe_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_tb import rob_pkg::*; ();

    typedef struct packed {
        rob_idx_t opid;
        logic [31:0] pc;
        logic [31:0] pnpc;
        logic [4:0] rd;
        logic executed;   // result written at an earlier edge
        logic [31:0] npc;
        logic exc;
        logic [5:0] cause;
    } model_t;

    typedef struct packed {
        logic [`COMMIT_WIDTH-1:0] valid;
        logic redir;
        logic [31:0] rpc;
        logic exc;
        logic [31:0] epc;
        logic [5:0] cause;
    } expect_t;

    logic clk, rst, disp_valid, disp_ready, exe_valid, exe_exc, redirect, exception;
    logic [31:0] disp_pc, disp_pnpc, exe_npc, redirect_pc, epc;
    logic [4:0] disp_rd;
    logic [5:0] exe_cause, cause;
    rob_idx_t disp_opid, exe_opid;
    logic [`COMMIT_WIDTH-1:0] com_valid;
    rob_idx_t [`COMMIT_WIDTH-1:0] com_opid;
    logic [`COMMIT_WIDTH-1:0][31:0] com_pc;
    logic [`COMMIT_WIDTH-1:0][4:0] com_rd;

    model_t q[$];      // live entries in program order
    expect_t exp_now;
    logic exp_ready, checking;
    rob_idx_t exp_tail;
    int full_cnt, dual_cnt, mp_cnt, exc_cnt, exc_split_cnt, mp_block_cnt, wait_cycles;

    rob_top rob_top_inst (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_ready(disp_ready), .disp_pc(disp_pc),
        .disp_pnpc(disp_pnpc), .disp_rd(disp_rd), .disp_opid(disp_opid),
        .exe_valid(exe_valid), .exe_opid(exe_opid), .exe_npc(exe_npc),
        .exe_exc(exe_exc), .exe_cause(exe_cause),
        .com_valid(com_valid), .com_opid(com_opid), .com_pc(com_pc), .com_rd(com_rd),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .exception(exception), .epc(epc), .cause(cause)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_opid(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_cause(input string name, input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    // in-order retirement from the head of the program-order queue
    function automatic expect_t ref_retire();
        expect_t e;
        model_t m;
        logic stop;
        e = '0;
        stop = 1'b0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (!stop && i < q.size()) m = q[i];
            if (stop || i >= q.size() || !m.executed) begin
                stop = 1'b1;
            end else if (m.exc) begin
                e.exc = 1'b1;    // excepting entry stays while fetch goes to the trap
                e.redir = 1'b1;
                e.rpc = `TRAP_VECTOR;
                e.epc = m.pc;
                e.cause = m.cause;
                stop = 1'b1;
            end else begin
                e.valid[i] = 1'b1;
                if (m.npc != m.pnpc) begin
                    e.redir = 1'b1;   // mispredict retires but later lanes do not
                    e.rpc = m.npc;
                    stop = 1'b1;
                end
            end
        end
        return e;
    endfunction

    task automatic drive_cycle(input int disp_pct, input int exe_pct);
        int cand[$];
        model_t m;
        int roll;
        disp_valid = ($urandom % 100) < disp_pct;
        disp_pc = $urandom & 32'hffff_fffc;
        disp_pnpc = ($urandom % 4 == 0) ? disp_pc + (($urandom % 64) << 2) : disp_pc + 4;
        disp_rd = 5'($urandom);
        exe_valid = 1'b0;
        for (int k = 0; k < q.size(); k++) begin
            m = q[k];
            if (!m.executed) cand.push_back(k);
        end
        if (cand.size() > 0 && ($urandom % 100) < exe_pct) begin
            m = q[cand[$urandom % cand.size()]];
            roll = $urandom % 100;
            exe_valid = 1'b1;
            exe_opid = m.opid;
            exe_npc = m.pnpc;
            exe_exc = (roll < 3);
            exe_cause = exe_exc ? 6'($urandom) : 6'd0;
            if (roll >= 3 && roll < 8) exe_npc = m.pnpc + 32'h40;   // wrong prediction
        end
    endtask

    always @(negedge clk) begin : compare
        model_t m;
        exp_now = ref_retire();
        exp_ready = (q.size() < `ROB_DEPTH) && !exp_now.redir;
        if (checking) begin
            check_flag("disp_ready", disp_ready, exp_ready);
            check_opid("disp_opid", disp_opid, exp_tail);
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                check_flag($sformatf("com_valid[%0d]", i), com_valid[i], exp_now.valid[i]);
                if (exp_now.valid[i]) begin
                    m = q[i];
                    check_opid($sformatf("com_opid[%0d]", i), com_opid[i], m.opid);
                    check_pc($sformatf("com_pc[%0d]", i), com_pc[i], m.pc);
                    check_rd($sformatf("com_rd[%0d]", i), com_rd[i], m.rd);
                end
            end
            check_flag("redirect", redirect, exp_now.redir);
            check_flag("exception", exception, exp_now.exc);
            if (exp_now.redir) check_pc("redirect_pc", redirect_pc, exp_now.rpc);
            if (exp_now.exc) begin
                check_pc("epc", epc, exp_now.epc);
                check_cause("cause", cause, exp_now.cause);
            end
            if (q.size() == `ROB_DEPTH) full_cnt++;
            if (exp_now.valid == '1) dual_cnt++;
            if (exp_now.redir && !exp_now.exc) mp_cnt++;
            if (exp_now.exc) exc_cnt++;
            if (exp_now.exc && exp_now.valid[0]) exc_split_cnt++;
            // mispredict in lane 0 while the next entry is already finished
            if (exp_now.redir && !exp_now.exc && !exp_now.valid[1] && q.size() > 1) begin
                m = q[1];
                if (m.executed) mp_block_cnt++;
            end
        end
    end

    always @(posedge clk) begin : model_update
        model_t m;
        if (rst) begin
            q.delete();
            exp_tail = '0;
        end else begin
            checking = 1'b1;
            if (exp_now.redir) begin
                q.delete();   // flush at this edge
                exp_tail = '0;
            end else begin
                for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                    if (exp_now.valid[i]) m = q.pop_front();
                end
                for (int k = 0; k < q.size(); k++) begin
                    m = q[k];
                    if (exe_valid && m.opid == exe_opid) begin
                        m.executed = 1'b1;
                        m.npc = exe_npc;
                        m.exc = exe_exc;
                        m.cause = exe_cause;
                        q[k] = m;
                    end
                end
                if (disp_valid && exp_ready) begin
                    m = '0;
                    m.opid = exp_tail;
                    m.pc = disp_pc;
                    m.pnpc = disp_pnpc;
                    m.rd = disp_rd;
                    q.push_back(m);
                    exp_tail = exp_tail + 1'b1;
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        checking = 1'b0;
        disp_valid = 1'b0;
        disp_pc = '0;
        disp_pnpc = '0;
        disp_rd = '0;
        exe_valid = 1'b0;
        exe_opid = '0;
        exe_npc = '0;
        exe_exc = 1'b0;
        exe_cause = '0;
        full_cnt = 0;
        dual_cnt = 0;
        mp_cnt = 0;
        exc_cnt = 0;
        exc_split_cnt = 0;
        mp_block_cnt = 0;
        wait_cycles = 0;
        void'($urandom(32'h0415_426d));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);                     // nothing may retire while idle
        repeat (24) begin                              // fill up
            @(negedge clk);
            drive_cycle(100, 0);
        end
        repeat (2000) begin
            @(negedge clk);
            drive_cycle(60, 80);
        end
        while (q.size() != 0 && wait_cycles < 400) begin
            @(negedge clk);
            drive_cycle(0, 100);
            wait_cycles++;
        end
        @(negedge clk);
        if (q.size() != 0) report_failure("buffer did not drain within 400 cycles");
        else if (full_cnt == 0) report_failure("buffer never reached full occupancy");
        else if (dual_cnt == 0) report_failure("no cycle retired two instructions");
        else if (mp_cnt == 0) report_failure("no mispredict redirect was exercised");
        else if (exc_cnt == 0) report_failure("no exception was exercised");
        else if (exc_split_cnt == 0) report_failure("no exception followed a retiring lane");
        else if (mp_block_cnt == 0) report_failure("no mispredict held back a finished lane");
        else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_ram.sv
hdl/rob_alloc.sv
hdl/rob_writeback.sv
hdl/rob_commit.sv
hdl/rob_top.sv
testbench/rob_tb.sv

// File: Bender.yml
package:
  name: rob

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rob_pkg.sv
      - hdl/rob_ram.sv
      - hdl/rob_alloc.sv
      - hdl/rob_writeback.sv
      - hdl/rob_commit.sv
      - hdl/rob_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/rob_tb.sv
